//--- tb.f
+incdir+include
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/rf_if.sv
hdl/prog_rom.sv
hdl/reg_file.sv
hdl/insn_decode.sv
hdl/alu.sv
hdl/risc_core.sv
hdl/risc_top.sv
dv/risc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=risc_tb_sim
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    -f tb.f --top-module risc_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- dv/risc_tb.sv
// ======================================================================
// Testbench for risc_top with random programs and an ISA reference model.
// Each program is 64 words and is loaded while rst is high. rst covers
// the load and then ten more cycles.
// Bodies use files 0..7 and forward GOTO targets only. The last word
// jumps to itself, so the port goes quiet once the program is done.
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "risc_settings.svh"

module risc_tb
    import isa_pkg::*;
();

    localparam int NUM_PROGS       = 20;
    localparam int PROG_LEN        = 64;
    localparam int LAST_SLOT       = PROG_LEN - 1;
    localparam int RESET_CYCLES    = 10;
    localparam int IDLE_CYCLES     = 200;
    localparam int PROG_CYCLES     = PROG_LEN * 3 + 230 + PROG_LEN + RESET_CYCLES;
    localparam int WATCHDOG_CYCLES = NUM_PROGS * PROG_CYCLES;

    logic                   clock;
    logic                   rst;
    logic                   load_en;
    logic [`PC_WIDTH-1:0]   load_addr;
    logic [`ROM_WIDTH-1:0]  load_data;
    logic [`DATA_WIDTH-1:0] port_out;
    logic                   port_valid;

    insn_t       prog [0:PROG_LEN-1];   // Current program image.
    logic [7:0]  exp_q [$];             // Expected port values, in order.
    logic [31:0] lfsr = 32'hf040_3c5d;  // Random state.

    risc_top dut_i (
        .clock      (clock),
        .rst        (rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .port_out   (port_out),
        .port_valid (port_valid)
    );

    // Galois LFSR with taps 32, 22, 2, 1; one step per returned bit.
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        logic        out_bit;
        int          i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            out_bit = lfsr[0];
            lfsr    = lfsr >> 1;
            if (out_bit)
            begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // Prologue, random body and a final jump to itself.
    function automatic void build_program();
        int          slot;
        int          span;
        opcode_e     op;
        logic        d;
        logic [2:0]  f;
        logic [7:0]  lit;
        logic [10:0] target;
        for (slot = 0; slot < 8; slot++)
        begin
            prog[slot] = {1'b0, MOVWF, 1'b1, 4'b0000, 3'(slot)}; // W is zero after reset.
        end
        for (slot = 8; slot < LAST_SLOT; slot++)
        begin
            if (take_bits(4) == 32'd0)
            begin
                span       = LAST_SLOT - slot;                   // Forward targets only.
                target     = 11'(slot + 1 + int'(take_bits(6)) % span);
                prog[slot] = {1'b1, target};
            end
            else
            begin
                op = opcode_e'(3'(take_bits(3)));
                d  = 1'(take_bits(1));
                f  = 3'(take_bits(3));                           // Files 0..7.
                if (take_bits(2) == 32'd0)
                begin
                    lit = 8'h01;                                 // Makes DECFSZ hits likely.
                end
                else
                begin
                    lit = 8'(take_bits(8));
                end
                if (op == DECFSZ && slot == LAST_SLOT - 1)
                begin
                    op = INCF;                                   // A skip must not leave the program.
                end
                if (op == MOVLW)
                begin
                    prog[slot] = {1'b0, op, lit};
                end
                else
                begin
                    prog[slot] = {1'b0, op, d, 4'b0000, f};
                end
            end
        end
        prog[LAST_SLOT] = {1'b1, 11'(LAST_SLOT)};                // Park here.
    endfunction

    // Interprets the program one word at a time and lists the port writes.
    function automatic void run_model();
        logic [7:0] files [0:`RF_DEPTH-1];
        logic [7:0] w;
        logic [7:0] src;
        logic [7:0] res;
        logic [6:0] fa;
        insn_t      word;
        opcode_e    op;
        int         pc;
        int         i;
        w  = 8'h00;                                              // W cleared by reset.
        pc = 0;
        for (i = 0; i < `RF_DEPTH; i++)
        begin
            files[i] = 8'h00;
        end
        exp_q.delete();
        while (pc != LAST_SLOT)
        begin
            word = prog[pc];
            if (word[11])
            begin
                pc = int'(word[10:0]);                           // GOTO.
            end
            else
            begin
                op  = opcode_e'(word[10:8]);
                fa  = word[6:0];
                src = files[fa];
                case (op)
                    MOVLW:   res = word[7:0];
                    MOVWF:   res = w;
                    MOVF:    res = src;
                    ADDWF:   res = w + src;                      // Wraps at 8 bits.
                    ANDWF:   res = w & src;
                    XORWF:   res = w ^ src;
                    INCF:    res = src + 8'd1;
                    default: res = src - 8'd1;                   // DECFSZ.
                endcase
                if (op == MOVLW)
                begin
                    w = res;
                end
                else if (op == MOVWF || word[7])
                begin
                    files[fa] = res;
                    if (fa == `PORT_ADDR)
                    begin
                        exp_q.push_back(res);
                    end
                end
                else
                begin
                    w = res;
                end
                pc = pc + 1;
                if (op == DECFSZ && res == 8'h00)
                begin
                    pc = pc + 1;                                 // Skip exactly one word.
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error at time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;                               // 8 ns period.
    end

    // Compares every port pulse with the next expected value.
    initial
    begin : port_checker
        logic [7:0] exp_val;
        forever
        begin
            @(negedge clock);
            if (port_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Unexpected port write of 0x%0h at time %0t", port_out, $time);
                    $display("Simulation failed");
                    $fatal(1);
                end
                else
                begin
                    exp_val = exp_q.pop_front();
                    check_value("port_out", 32'(port_out), 32'(exp_val));
                end
            end
        end
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    end

    initial
    begin : main_sequence
        int p;
        int a;
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        for (p = 0; p < NUM_PROGS; p++)
        begin
            @(negedge clock);
            rst = 1'b1;                                          // Core parked during the load.
            build_program();
            for (a = 0; a < PROG_LEN; a++)
            begin
                load_en   = 1'b1;
                load_addr = 11'(a);
                load_data = prog[a];
                @(negedge clock);
            end
            load_en = 1'b0;
            repeat (RESET_CYCLES) @(negedge clock);
            check_value("port_valid", 32'(port_valid), 32'd0);   // Quiet in reset.
            check_value("port_out", 32'(port_out), 32'd0);
            run_model();
            rst = 1'b0;                                          // Start at address 0.
            while (exp_q.size() != 0)
            begin
                @(negedge clock);
            end
            repeat (IDLE_CYCLES) @(negedge clock);               // Extra pulses fail here.
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/risc_top.sv
// ======================================================================
// Top level: program ROM, file registers and core.
// Load the ROM through load_* while rst is high; execution starts
// at address 0 once rst is released.
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "risc_settings.svh"

module risc_top (
    input  wire logic                   clock,
    input  wire logic                   rst,
    input  wire logic                   load_en,    // ROM loader strobe.
    input  wire logic [`PC_WIDTH-1:0]   load_addr,  // ROM loader address.
    input  wire logic [`ROM_WIDTH-1:0]  load_data,  // ROM loader word.
    output logic      [`DATA_WIDTH-1:0] port_out,   // Output port value.
    output logic                        port_valid  // Output port strobe.
);

    logic [`PC_WIDTH-1:0]  rom_addr; // Core fetch address.
    logic [`ROM_WIDTH-1:0] insn;     // Fetched word.

    rf_if rf_bus ();                 // Core to file memory.

    prog_rom rom_i (
        .clock     (clock),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_addr   (rom_addr),
        .insn      (insn)
    );

    reg_file rf_i (
        .clock (clock),
        .rf    (rf_bus.mem)
    );

    risc_core core_i (
        .clock      (clock),
        .rst        (rst),
        .rom_addr   (rom_addr),
        .insn       (insn),
        .rf         (rf_bus.core),
        .port_out   (port_out),
        .port_valid (port_valid)
    );

endmodule

`default_nettype wire

//--- hdl/risc_core.sv
// ======================================================================
// Three-stage core: fetch, decode with file read, execute with write.
// One instruction enters per cycle; the core never stalls.
// A taken GOTO squashes two younger slots, a taken skip squashes one.
// Writes to PORT_ADDR are copied to port_out with a one-cycle pulse.
// Register file contents are not cleared by rst.
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "risc_settings.svh"

module risc_core
    import isa_pkg::*,
           core_pkg::*;
(
    input  wire logic clock,
    input  wire logic rst,
    output pc_t       rom_addr,   // Fetch address.
    input  wire insn_t insn,      // Word fetched last cycle.
    rf_if.core        rf,         // File register port.
    output data_t     port_out,   // Last value written to PORT_ADDR.
    output logic      port_valid  // One-cycle pulse per port write.
);

    pc_t   pc;          // Fetch program counter.
    logic  dec_valid;   // Decode slot holds a live word.
    logic  ex_valid;    // Execute slot holds a live instruction.
    ctrl_t dec_ctrl;    // Decode stage control.
    ctrl_t ex_ctrl;     // Execute stage control.
    data_t w;           // Working register.
    data_t alu_result;
    logic  alu_zero;
    logic  take_goto;   // Jump in execute.
    logic  take_skip;   // DECFSZ hit zero in execute.
    logic  ex_write_f;  // Live file write.

    insn_decode decode_i (
        .insn (insn),
        .ctrl (dec_ctrl)
    );

    alu alu_i (
        .op     (ex_ctrl.alu_op),
        .w      (w),
        .f      (rf.q),              // File value for this instruction.
        .lit    (ex_ctrl.literal),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign take_goto  = ex_valid & ex_ctrl.is_goto;
    assign take_skip  = ex_valid & ex_ctrl.is_skip & alu_zero;
    assign ex_write_f = ex_valid & ex_ctrl.write_f;

    assign rom_addr     = pc;
    assign rf.rdaddress = dec_ctrl.f_addr;   // q returns in execute.
    assign rf.wren      = ex_write_f;
    assign rf.wraddress = ex_ctrl.f_addr;
    assign rf.data      = alu_result;

    // Control state: PC, slot valids, W and the port.
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc         <= '0;
            dec_valid  <= 1'b0;
            ex_valid   <= 1'b0;
            w          <= '0;
            port_out   <= '0;
            port_valid <= 1'b0;
        end
        else
        begin
            pc        <= take_goto ? ex_ctrl.target : pc + 1'b1;
            dec_valid <= ~take_goto;                          // Drop the fetched word.
            ex_valid  <= dec_valid & ~take_goto & ~take_skip; // Drop the decoded word.
            if (ex_valid && ex_ctrl.write_w)
            begin
                w <= alu_result;
            end
            port_valid <= ex_write_f && (ex_ctrl.f_addr == `PORT_ADDR);
            if (ex_write_f && (ex_ctrl.f_addr == `PORT_ADDR))
            begin
                port_out <= alu_result; // Held until the next port write.
            end
        end
    end

    // Execute payload, qualified by ex_valid.
    always_ff @(posedge clock)
    begin
        ex_ctrl <= dec_ctrl;
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
// ======================================================================
// 8-bit datapath for the execute stage.
// All arithmetic wraps modulo 256; no carry or status is produced.
// zero flags an all-zero result for the DECFSZ skip.
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module alu
    import isa_pkg::*,
           core_pkg::*;
(
    input  wire alu_op_e op,     // Function select.
    input  wire data_t   w,      // W register.
    input  wire data_t   f,      // File value.
    input  wire data_t   lit,    // Literal.
    output data_t        result, // Operation result.
    output logic         zero    // Result is zero.
);

    always_comb
    begin
        case (op)
            ALU_PASS_LIT: result = lit;
            ALU_PASS_W:   result = w;
            ALU_PASS_F:   result = f;
            ALU_ADD:      result = w + f;      // Carry dropped.
            ALU_AND:      result = w & f;
            ALU_XOR:      result = w ^ f;
            ALU_INC:      result = f + 8'd1;   // 0xFF wraps to 0x00.
            ALU_DEC:      result = f - 8'd1;   // 0x00 wraps to 0xFF.
            default:      result = w;
        endcase
    end

    assign zero = (result == '0); // Used for DECFSZ.

endmodule

`default_nettype wire

//--- hdl/insn_decode.sv
// ======================================================================
// Instruction decoder, purely combinational.
// Maps GOTO and the eight file/literal operations onto ctrl_t.
// MOVWF always writes f, MOVLW always writes W; the rest follow d.
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module insn_decode
    import isa_pkg::*,
           core_pkg::*;
(
    input  wire insn_t insn, // Word from the ROM.
    output ctrl_t      ctrl  // Decoded control.
);

    op_word_t   op_word;   // File operation view.
    lit_word_t  lit_word;  // Literal view.
    goto_word_t goto_word; // Jump view.
    logic       dest_f;    // Destination is the file.

    assign op_word   = op_word_t'(insn);
    assign lit_word  = lit_word_t'(insn);
    assign goto_word = goto_word_t'(insn);
    assign dest_f    = op_word.d;

    always_comb
    begin
        ctrl         = '0;                 // No writes, no jump by default.
        ctrl.alu_op  = ALU_PASS_W;
        ctrl.f_addr  = op_word.f;          // Also read address in decode.
        ctrl.literal = lit_word.lit;
        ctrl.target  = goto_word.target;

        if (op_word.goto_bit)
        begin
            ctrl.is_goto = 1'b1;           // Bit 11 wins over the opcode.
        end
        else
        begin
            case (op_word.op)
                MOVLW:  ctrl.alu_op = ALU_PASS_LIT;
                MOVWF:  ctrl.alu_op = ALU_PASS_W;
                MOVF:   ctrl.alu_op = ALU_PASS_F;
                ADDWF:  ctrl.alu_op = ALU_ADD;
                ANDWF:  ctrl.alu_op = ALU_AND;
                XORWF:  ctrl.alu_op = ALU_XOR;
                INCF:   ctrl.alu_op = ALU_INC;
                DECFSZ: ctrl.alu_op = ALU_DEC;
                default: ctrl.alu_op = ALU_PASS_W;
            endcase

            case (op_word.op)
                MOVLW:   ctrl.write_w = 1'b1;  // Literal always to W.
                MOVWF:   ctrl.write_f = 1'b1;  // W always to f.
                default:
                begin
                    ctrl.write_f = dest_f;     // d = 1 writes f.
                    ctrl.write_w = ~dest_f;    // d = 0 writes W.
                end
            endcase

            ctrl.is_skip = (op_word.op == DECFSZ); // Skip resolved in execute.
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// ======================================================================
// 128 x 8 file register memory.
// The write request is registered and committed one cycle later.
// A read of the address being committed returns the pending data.
// The read address is registered; q is valid the following cycle.
// No reset; contents are undefined after power-up.
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "risc_settings.svh"

module reg_file (
    input wire logic clock,
    rf_if.mem        rf     // Core-facing port.
);

    logic [`DATA_WIDTH-1:0]    mem [0:`RF_DEPTH-1]; // File storage.

    logic                      r_we;      // Pending write strobe.
    logic [`RF_ADDR_WIDTH-1:0] r_wr_addr; // Pending write address.
    logic [`DATA_WIDTH-1:0]    r_data;    // Pending write data, full width.
    logic [`RF_ADDR_WIDTH-1:0] r_rd_addr; // Registered read address.

    // Capture the write request and the read address.
    always_ff @(posedge clock)
    begin
        r_we      <= rf.wren;
        r_wr_addr <= rf.wraddress;
        r_data    <= rf.data;
        r_rd_addr <= rf.rdaddress;
    end

    // Commit the pending write.
    always_ff @(posedge clock)
    begin
        if (r_we)
        begin
            mem[r_wr_addr] <= r_data; // Stored at the end of the commit cycle.
        end
    end

    // Same-address read during commit sees the new value.
    assign rf.q = (r_we && (r_rd_addr == r_wr_addr)) ? r_data : mem[r_rd_addr];

endmodule

`default_nettype wire

//--- hdl/prog_rom.sv
// ======================================================================
// Program memory, 2048 x 12, with a registered read.
// Word at rd_addr appears on insn one cycle later.
// The load port is meant to be used while the core is held in reset.
// Contents are undefined until loaded.
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "risc_settings.svh"

module prog_rom
    import isa_pkg::*;
(
    input  wire logic                 clock,
    input  wire logic                 load_en,   // Loader write strobe.
    input  wire logic [`PC_WIDTH-1:0] load_addr, // Loader word address.
    input  wire insn_t                load_data, // Loader word.
    input  wire logic [`PC_WIDTH-1:0] rd_addr,   // Fetch address.
    output insn_t                     insn       // Fetched word, one cycle late.
);

    insn_t mem [0:`ROM_DEPTH-1]; // Program store.

    // Loader write port.
    always_ff @(posedge clock)
    begin
        if (load_en)
        begin
            mem[load_addr] <= load_data; // Store one program word.
        end
    end

    // Synchronous fetch port.
    always_ff @(posedge clock)
    begin
        insn <= mem[rd_addr]; // Registered read, no reset.
    end

endmodule

`default_nettype wire

//--- hdl/rf_if.sv
// ======================================================================
// Register file port bundle between the core and the file memory.
// Plain strobes, no handshake. The core side writes and addresses;
// the memory side returns q one cycle after the read address.
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "risc_settings.svh"

interface rf_if;

    logic [`DATA_WIDTH-1:0]    data;      // Write data.
    logic                      wren;      // Write strobe.
    logic [`RF_ADDR_WIDTH-1:0] wraddress; // Write address.
    logic [`RF_ADDR_WIDTH-1:0] rdaddress; // Read address, registered in memory.
    logic [`DATA_WIDTH-1:0]    q;         // Read data.

    modport core (
        output data, wren, wraddress, rdaddress,
        input  q
    );

    modport mem (
        input  data, wren, wraddress, rdaddress,
        output q
    );

endinterface

`default_nettype wire

//--- hdl/core_pkg.sv
// ======================================================================
// Internal pipeline types of the core.
// ctrl_t is produced in decode and registered into execute.
// ======================================================================
`default_nettype none

package core_pkg;

    import isa_pkg::*;

    // ALU function select.
    typedef enum logic [2:0] {
        ALU_PASS_LIT = 3'd0, // Literal through.
        ALU_PASS_W   = 3'd1, // W through.
        ALU_PASS_F   = 3'd2, // File value through.
        ALU_ADD      = 3'd3,
        ALU_AND      = 3'd4,
        ALU_XOR      = 3'd5,
        ALU_INC      = 3'd6, // f + 1.
        ALU_DEC      = 3'd7  // f - 1.
    } alu_op_e;

    // Decoded control for one instruction.
    typedef struct packed {
        alu_op_e    alu_op;
        logic       write_w;  // Result to W.
        logic       write_f;  // Result to file f.
        logic       is_goto;  // Unconditional jump.
        logic       is_skip;  // Skip next when result is zero.
        file_addr_t f_addr;   // Source and destination file.
        data_t      literal;  // MOVLW operand.
        pc_t        target;   // GOTO target.
    } ctrl_t;

endpackage

`default_nettype wire

//--- hdl/isa_pkg.sv
// ======================================================================
// Instruction set of the core: opcodes and instruction word layouts.
// Bit 11 selects GOTO; otherwise bits 10..8 carry the opcode.
// No status flags, no stack, no indirect addressing.
// ======================================================================
`default_nettype none

`include "risc_settings.svh"

package isa_pkg;

    typedef logic [`ROM_WIDTH-1:0]     insn_t;      // Raw instruction word.
    typedef logic [`RF_ADDR_WIDTH-1:0] file_addr_t; // File register address.
    typedef logic [`DATA_WIDTH-1:0]    data_t;      // Datapath byte.
    typedef logic [`PC_WIDTH-1:0]      pc_t;        // Program address.

    // File and literal operations, bits 10..8.
    typedef enum logic [2:0] {
        MOVLW  = 3'd0, // W = k.
        MOVWF  = 3'd1, // f = W.
        MOVF   = 3'd2, // dest = f.
        ADDWF  = 3'd3, // dest = W + f.
        ANDWF  = 3'd4, // dest = W & f.
        XORWF  = 3'd5, // dest = W ^ f.
        INCF   = 3'd6, // dest = f + 1.
        DECFSZ = 3'd7  // dest = f - 1, skip if zero.
    } opcode_e;

    // File operation layout.
    typedef struct packed {
        logic       goto_bit; // Set for GOTO.
        opcode_e    op;       // Operation.
        logic       d;        // 1 writes f, 0 writes W.
        file_addr_t f;        // File address.
    } op_word_t;

    // MOVLW layout; the literal overlays d and f.
    typedef struct packed {
        logic    goto_bit;
        opcode_e op;
        data_t   lit;         // Literal byte.
    } lit_word_t;

    // GOTO layout.
    typedef struct packed {
        logic goto_bit;
        pc_t  target;         // Absolute jump target.
    } goto_word_t;

endpackage

`default_nettype wire

//--- include/risc_settings.svh
// ======================================================================
// Build-wide widths and depths for the 8-bit accumulator core.
// The program address width and the ROM depth must agree (2^11).
// PORT_ADDR must lie inside the 128-entry register file.
// Changing DATA_WIDTH is not supported; the ISA assumes 8-bit data.
// ======================================================================
`ifndef RISC_SETTINGS_SVH
`define RISC_SETTINGS_SVH

`define PC_WIDTH      11    // Program counter and GOTO target width.
`define ROM_DEPTH     2048  // Program words.
`define ROM_WIDTH     12    // Instruction word width.

`define DATA_WIDTH    8     // W, file registers and ALU width.

`define RF_ADDR_WIDTH 7     // File address width.
`define RF_DEPTH      128   // File registers.

// File address mapped onto the output port.
`define PORT_ADDR     7'h06

`endif
